/* filelist.f */
+incdir+rtl
rtl/conv_input_pkg.sv
rtl/conv_input_ctrl.sv
rtl/row_bank.sv
rtl/window_shifter.sv
rtl/conv_input_cache.sv
sim/conv_input_checker.sv
sim/tb_conv_input_cache.sv

/* rtl/conv_input_cache.sv */
`include "conv_input_config.svh"

module conv_input_cache (
	input  logic                    clk,
	input  logic                    rst_n,
	input  conv_input_pkg::cmd_e    cmd,
	input  conv_input_pkg::pixel_t  pixel_in,
	output conv_input_pkg::ack_e    ack,
	output logic [`ADDR_W-1:0]      rom_addr,
	output conv_input_pkg::window_t out_window,
	output logic                    out_valid
);

	conv_input_pkg::row_wr_t row_wr;
	conv_input_pkg::shift_ctl_t shift_ctl;
	conv_input_pkg::rows_t rows;

	// fetch side and window sequencing
	conv_input_ctrl u_ctrl (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.ack       (ack),
		.rom_addr  (rom_addr),
		.pixel_in  (pixel_in),
		.row_wr    (row_wr),
		.shift_ctl (shift_ctl)
	);

	row_bank u_row_bank (
		.clk    (clk),
		.rst_n  (rst_n),
		.row_wr (row_wr),
		.rows   (rows)
	);

	// drives the conv array
	window_shifter u_window_shifter (
		.clk        (clk),
		.rst_n      (rst_n),
		.rows       (rows),
		.shift_ctl  (shift_ctl),
		.out_window (out_window),
		.out_valid  (out_valid)
	);

endmodule

/* rtl/conv_input_config.svh */
`ifndef CONV_INPUT_CONFIG_SVH
`define CONV_INPUT_CONFIG_SVH

// pixel word width
`define PIXEL_W 32

// pixels per image row
`define IMAGE_W 8

// kernel rows, also window positions per row
`define KERNEL_N 3

// lanes driven into the array
`define WINDOW_W (`IMAGE_W - `KERNEL_N + 1)

`define ADDR_W 6

// ieee 754 single 1.0, bias lanes
`define FLOAT_ONE 32'h3F80_0000

`endif

/* rtl/conv_input_ctrl.sv */
`include "conv_input_config.svh"

module conv_input_ctrl (
	input  logic                       clk,
	input  logic                       rst_n,
	input  conv_input_pkg::cmd_e       cmd,
	output conv_input_pkg::ack_e       ack,
	output logic [`ADDR_W-1:0]         rom_addr,
	input  conv_input_pkg::pixel_t     pixel_in,
	output conv_input_pkg::row_wr_t    row_wr,
	output conv_input_pkg::shift_ctl_t shift_ctl
);

	localparam conv_input_pkg::slot_t SLOT_LAST = conv_input_pkg::slot_t'(`IMAGE_W - 1);
	localparam conv_input_pkg::row_idx_t ROW_LAST = conv_input_pkg::row_idx_t'(`KERNEL_N - 1);

	conv_input_pkg::state_e state;
	conv_input_pkg::slot_t slot_cnt;
	conv_input_pkg::row_idx_t row_cnt;
	conv_input_pkg::row_idx_t pos_cnt;
	logic read_cyc;
	logic slot_last;
	logic row_last;
	logic pos_last;

	assign read_cyc = (state == conv_input_pkg::ST_PRELOAD) || (state == conv_input_pkg::ST_LOAD);
	assign slot_last = (slot_cnt == SLOT_LAST);
	assign row_last = (row_cnt == ROW_LAST);
	// positions per row equal kernel rows
	assign pos_last = (pos_cnt == ROW_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= conv_input_pkg::ST_IDLE;
			slot_cnt <= '0;
			row_cnt <= '0;
			pos_cnt <= '0;
			ack <= conv_input_pkg::ACK_NONE;
		end else begin
			ack <= conv_input_pkg::ACK_NONE;
			case (state)
				conv_input_pkg::ST_IDLE: begin
					slot_cnt <= '0;
					row_cnt <= '0;
					pos_cnt <= '0;
					case (cmd)
						conv_input_pkg::CMD_PRELOAD: state <= conv_input_pkg::ST_PRELOAD;
						conv_input_pkg::CMD_SHIFT: state <= conv_input_pkg::ST_SHIFT;
						conv_input_pkg::CMD_LOAD: state <= conv_input_pkg::ST_LOAD;
						default: state <= conv_input_pkg::ST_IDLE;
					endcase
				end
				conv_input_pkg::ST_PRELOAD: begin
					slot_cnt <= slot_cnt + 1'b1;
					if (slot_last) begin
						row_cnt <= row_cnt + 1'b1;
						if (row_last) begin
							state <= conv_input_pkg::ST_IDLE;
							ack <= conv_input_pkg::ACK_PRELOAD_DONE;
						end
					end
				end
				conv_input_pkg::ST_LOAD: begin
					// one row only
					slot_cnt <= slot_cnt + 1'b1;
					if (slot_last) begin
						state <= conv_input_pkg::ST_IDLE;
						ack <= conv_input_pkg::ACK_LOAD_DONE;
					end
				end
				conv_input_pkg::ST_SHIFT: begin
					if (pos_last) begin
						pos_cnt <= '0;
						row_cnt <= row_cnt + 1'b1;
						if (row_last)
							state <= conv_input_pkg::ST_BIAS;
					end else begin
						pos_cnt <= pos_cnt + 1'b1;
					end
				end
				conv_input_pkg::ST_BIAS: begin
					// lands together with the bias window
					state <= conv_input_pkg::ST_IDLE;
					ack <= conv_input_pkg::ACK_SHIFT_DONE;
				end
				default: state <= conv_input_pkg::ST_IDLE;
			endcase
		end
	end

	// address moves only on reads, wraps at 64
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rom_addr <= '0;
		else if (read_cyc)
			rom_addr <= rom_addr + 1'b1;
	end

	always_comb begin
		row_wr.write = read_cyc;
		row_wr.last = read_cyc && slot_last;
		row_wr.slot = slot_cnt;
		row_wr.pixel = pixel_in;
	end

	always_comb begin
		shift_ctl.row_sel = row_cnt;
		case (state)
			conv_input_pkg::ST_SHIFT:
				shift_ctl.op = (pos_cnt == '0) ? conv_input_pkg::OP_LOAD_ROW
					: conv_input_pkg::OP_SHIFT;
			conv_input_pkg::ST_BIAS: shift_ctl.op = conv_input_pkg::OP_BIAS;
			default: shift_ctl.op = conv_input_pkg::OP_CLEAR;
		endcase
	end

endmodule

/* rtl/conv_input_pkg.sv */
`include "conv_input_config.svh"

package conv_input_pkg;

	typedef logic [`PIXEL_W-1:0] pixel_t;
	typedef pixel_t [`IMAGE_W-1:0] row_t;
	// row 0 is the oldest
	typedef row_t [`KERNEL_N-1:0] rows_t;
	// lane 0 is leftmost
	typedef pixel_t [`WINDOW_W-1:0] window_t;

	typedef logic [$clog2(`IMAGE_W)-1:0] slot_t;
	typedef logic [$clog2(`KERNEL_N)-1:0] row_idx_t;

	typedef enum logic [1:0] {CMD_NONE, CMD_PRELOAD, CMD_SHIFT, CMD_LOAD} cmd_e;

	typedef enum logic [1:0] {
		ACK_NONE,
		ACK_PRELOAD_DONE,
		ACK_SHIFT_DONE,
		ACK_LOAD_DONE
	} ack_e;

	typedef enum logic [2:0] {ST_IDLE, ST_PRELOAD, ST_SHIFT, ST_BIAS, ST_LOAD} state_e;

	typedef enum logic [2:0] {OP_HOLD, OP_LOAD_ROW, OP_SHIFT, OP_BIAS, OP_CLEAR} shift_op_e;

	typedef struct packed {
		logic write;
		logic last;
		slot_t slot;
		pixel_t pixel;
	} row_wr_t;

	typedef struct packed {
		shift_op_e op;
		row_idx_t row_sel;
	} shift_ctl_t;

endpackage

/* rtl/row_bank.sv */
`include "conv_input_config.svh"

module row_bank (
	input  logic                    clk,
	input  logic                    rst_n,
	input  conv_input_pkg::row_wr_t row_wr,
	output conv_input_pkg::rows_t   rows
);

	conv_input_pkg::row_t fill_row;
	conv_input_pkg::row_t fill_next;

	// incoming pixel merged into the partial row
	always_comb begin
		fill_next = fill_row;
		fill_next[row_wr.slot] = row_wr.pixel;
	end

	always_ff @(posedge clk) begin
		if (row_wr.write)
			fill_row <= fill_next;
	end

	// oldest row drops out, newest enters at the top
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rows <= '0;
		end else if (row_wr.write && row_wr.last) begin
			for (int i = 0; i < `KERNEL_N - 1; i++) begin
				rows[i] <= rows[i+1];
			end
			rows[`KERNEL_N-1] <= fill_next;
		end
	end

endmodule

/* rtl/window_shifter.sv */
`include "conv_input_config.svh"

module window_shifter (
	input  logic                       clk,
	input  logic                       rst_n,
	input  conv_input_pkg::rows_t      rows,
	input  conv_input_pkg::shift_ctl_t shift_ctl,
	output conv_input_pkg::window_t    out_window,
	output logic                       out_valid
);

	// full row, only the left lanes leave the module
	conv_input_pkg::row_t win_reg;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			win_reg <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= shift_ctl.op inside {conv_input_pkg::OP_LOAD_ROW,
				conv_input_pkg::OP_SHIFT, conv_input_pkg::OP_BIAS};
			case (shift_ctl.op)
				conv_input_pkg::OP_LOAD_ROW: begin
					win_reg <= rows[shift_ctl.row_sel];
				end
				conv_input_pkg::OP_SHIFT: begin
					// next pixel slides into lane 0
					win_reg <= {{`PIXEL_W{1'b0}}, win_reg[`IMAGE_W-1:1]};
				end
				conv_input_pkg::OP_BIAS: begin
					win_reg <= {`IMAGE_W{`FLOAT_ONE}};
				end
				conv_input_pkg::OP_CLEAR: begin
					win_reg <= '0;
				end
				default: begin
					win_reg <= win_reg;
				end
			endcase
		end
	end

	assign out_window = win_reg[`WINDOW_W-1:0];

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
out=$(verilator --binary --assert --timing -f filelist.f --top-module tb_conv_input_cache \
	&& ./obj_dir/Vtb_conv_input_cache 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Finished with no errors" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/conv_input_checker.sv */
`include "conv_input_config.svh"

module conv_input_checker (
	input logic                 clk,
	input logic                 rst_n,
	input conv_input_pkg::ack_e ack,
	input logic [`ADDR_W-1:0]   rom_addr,
	input logic                 out_valid
);

	int fail_count = 0;

	// ack is a single cycle pulse
	ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		(ack != conv_input_pkg::ACK_NONE) |=> (ack == conv_input_pkg::ACK_NONE))
	else begin
		$error("ack stayed active for two cycles");
		fail_count++;
	end

	// fetch acks never overlap a window
	no_window_on_fetch_ack: assert property (@(posedge clk) disable iff (!rst_n)
		!(out_valid && (ack == conv_input_pkg::ACK_PRELOAD_DONE
			|| ack == conv_input_pkg::ACK_LOAD_DONE)))
	else begin
		$error("out_valid high together with a fetch ack");
		fail_count++;
	end

	addr_stable_on_window: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $stable(rom_addr))
	else begin
		$error("rom_addr moved while out_valid was high");
		fail_count++;
	end

endmodule

/* sim/tb_conv_input_cache.sv */
`include "conv_input_config.svh"

module tb_conv_input_cache;

	localparam int TIMEOUT = 200;
	localparam int NUM_WIN = `KERNEL_N * `KERNEL_N + 1;

	logic clk = 1'b0;
	logic rst_n = 1'b0;
	conv_input_pkg::cmd_e cmd = conv_input_pkg::CMD_NONE;
	conv_input_pkg::pixel_t pixel_in = '0;
	conv_input_pkg::ack_e ack;
	logic [`ADDR_W-1:0] rom_addr;
	conv_input_pkg::window_t out_window;
	logic out_valid;

	conv_input_pkg::pixel_t mem [0:(1 << `ADDR_W) - 1];
	logic [`ADDR_W-1:0] exp_addr;
	integer seed;
	int error_count = 0;

	conv_input_cache uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.cmd        (cmd),
		.pixel_in   (pixel_in),
		.ack        (ack),
		.rom_addr   (rom_addr),
		.out_window (out_window),
		.out_valid  (out_valid)
	);

	bind conv_input_cache conv_input_checker u_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.ack       (ack),
		.rom_addr  (rom_addr),
		.out_valid (out_valid)
	);

	always #20 clk = ~clk;

	// pixel memory, word follows rom_addr
	always @(negedge clk) pixel_in <= mem[rom_addr];

	task automatic fill_memory;
		logic [31:0] rnd;
		for (int a = 0; a < (1 << `ADDR_W); a++) begin
			rnd = $random(seed);
			mem[a[`ADDR_W-1:0]] = {a[`ADDR_W-1:0], rnd[`PIXEL_W-`ADDR_W-1:0]};
		end
	endtask

	task automatic check_ack(input string name, input conv_input_pkg::ack_e exp,
		input conv_input_pkg::ack_e act);
		if (act !== exp) begin
			error_count++;
			$display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_window(input string name, input conv_input_pkg::window_t exp,
		input conv_input_pkg::window_t act);
		if (act !== exp) begin
			error_count++;
			$display("ERR %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input logic [`ADDR_W-1:0] exp,
		input logic [`ADDR_W-1:0] act);
		if (act !== exp) begin
			error_count++;
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_valid(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			error_count++;
			$display("ERR %s: expected out_valid %b, actual %b", name, exp, act);
		end
	endtask

	task automatic apply_reset;
		@(negedge clk);
		rst_n = 1'b0;
		cmd = conv_input_pkg::CMD_NONE;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		exp_addr = '0;
	endtask

	task automatic send_cmd(input conv_input_pkg::cmd_e c);
		@(negedge clk);
		cmd = c;
		@(negedge clk);
		cmd = conv_input_pkg::CMD_NONE;
	endtask

	task automatic wait_ack(input string name, output conv_input_pkg::ack_e seen);
		int n;
		n = 0;
		while (ack == conv_input_pkg::ACK_NONE && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (ack == conv_input_pkg::ACK_NONE) begin
			error_count++;
			$display("%s: timed out waiting for an ack", name);
		end
		seen = ack;
	endtask

	task automatic run_preload(input string name);
		conv_input_pkg::ack_e seen;
		send_cmd(conv_input_pkg::CMD_PRELOAD);
		wait_ack(name, seen);
		check_ack(name, conv_input_pkg::ACK_PRELOAD_DONE, seen);
		exp_addr = exp_addr + `ADDR_W'(`KERNEL_N * `IMAGE_W);
		check_addr(name, exp_addr, rom_addr);
	endtask

	task automatic run_load(input string name);
		conv_input_pkg::ack_e seen;
		send_cmd(conv_input_pkg::CMD_LOAD);
		wait_ack(name, seen);
		check_ack(name, conv_input_pkg::ACK_LOAD_DONE, seen);
		exp_addr = exp_addr + `ADDR_W'(`IMAGE_W);
		check_addr(name, exp_addr, rom_addr);
	endtask

	// oldest row starts three rows behind the address counter
	task automatic run_shift(input string name);
		logic [`ADDR_W-1:0] base;
		logic [`ADDR_W-1:0] a;
		conv_input_pkg::window_t exp_win;
		int n;
		base = exp_addr - `ADDR_W'(`KERNEL_N * `IMAGE_W);
		send_cmd(conv_input_pkg::CMD_SHIFT);
		n = 0;
		while (!out_valid && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (!out_valid) begin
			error_count++;
			$display("%s: timed out waiting for the first window", name);
		end else begin
			for (int w = 0; w < NUM_WIN; w++) begin
				check_valid(name, 1'b1, out_valid);
				for (int i = 0; i < `WINDOW_W; i++) begin
					a = base + `ADDR_W'((w / `KERNEL_N) * `IMAGE_W + (w % `KERNEL_N) + i);
					exp_win[i] = (w == NUM_WIN - 1) ? `FLOAT_ONE : mem[a];
				end
				check_window(name, exp_win, out_window);
				check_ack(name, (w == NUM_WIN - 1) ? conv_input_pkg::ACK_SHIFT_DONE
					: conv_input_pkg::ACK_NONE, ack);
				@(negedge clk);
			end
			// no window after the bias window
			check_valid(name, 1'b0, out_valid);
		end
	endtask

	task automatic test_reset;
		apply_reset();
		check_ack("reset", conv_input_pkg::ACK_NONE, ack);
		check_addr("reset", '0, rom_addr);
		check_window("reset", '0, out_window);
		check_valid("reset", 1'b0, out_valid);
	endtask

	task automatic test_ignored_cmd;
		conv_input_pkg::ack_e seen;
		send_cmd(conv_input_pkg::CMD_PRELOAD);
		repeat (3) @(negedge clk);
		send_cmd(conv_input_pkg::CMD_SHIFT);
		wait_ack("ignored_cmd", seen);
		check_ack("ignored_cmd", conv_input_pkg::ACK_PRELOAD_DONE, seen);
		exp_addr = exp_addr + `ADDR_W'(`KERNEL_N * `IMAGE_W);
		check_addr("ignored_cmd", exp_addr, rom_addr);
		for (int n = 0; n < 40; n++) begin
			@(negedge clk);
			if (ack != conv_input_pkg::ACK_NONE || out_valid) begin
				error_count++;
				$display("ignored_cmd: the shift sent during preload was still executed");
			end
		end
	endtask

	task automatic test_wrap;
		apply_reset();
		run_preload("wrap_preload");
		repeat (3) run_load("wrap_load");
		check_addr("wrap_48", `ADDR_W'(48), rom_addr);
		repeat (5) run_load("wrap_load");
		check_addr("wrap_24", `ADDR_W'(24), rom_addr);
		run_shift("wrap_shift");
	endtask

	initial begin
		seed = 78;
		fill_memory();
		test_reset();
		run_preload("preload");
		run_shift("shift");
		run_load("load");
		run_shift("load_shift");
		test_ignored_cmd();
		test_wrap();
		$display("check errors: %0d, assertion failures: %0d", error_count,
			uut.u_checker.fail_count);
		if (error_count == 0 && uut.u_checker.fail_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
